/* Bender.yml */
package:
  name: tick_counter

sources:
  - include_dirs:
      - include
    files:
      - rtl/tick_counter_pkg.sv
      - rtl/cnt_cfg_regs.sv
      - rtl/tick_prescaler.sv
      - rtl/event_counter.sv
      - rtl/vled_status.sv
      - rtl/tick_counter_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tick_counter_properties.sv
      - testbench/tb_tick_counter.sv

/* include/tick_counter_defines.svh */
// Tick counter width macros

`ifndef TICK_COUNTER_DEFINES_SVH
`define TICK_COUNTER_DEFINES_SVH

//----------------------------------------
// Widths
//----------------------------------------

// Tick divider and prescaler count
`define TC_TICK_W 8

// Event counter, load value and watermark
`define TC_CNT_W 16

// Virtual LEDs and DIP switches
`define TC_LED_W 16

// Command data word
`define TC_DATA_W 16

`endif

/* rtl/cnt_cfg_regs.sv */
// Command decode and config registers

`timescale 1ns/1ps
`default_nettype none

`include "tick_counter_defines.svh"

module cnt_cfg_regs (
  input  logic                       clk_main_a0,
  input  logic                       rst_main_n_sync,
  input  tick_counter_pkg::cmd_t     cmd,
  output tick_counter_pkg::cnt_cfg_t cfg,
  output tick_counter_pkg::cnt_pulse_t pulse,
  output logic [`TC_LED_W-1:0]       led_value
);

  //----------------------------------------
  // Configuration registers
  //----------------------------------------

  // Every strobe is taken, nothing stalls
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      cfg       <= '0;
      led_value <= '0;
    end else if (cmd.strobe) begin
      case (cmd.op)
        tick_counter_pkg::OP_SET_CTRL: begin
          // Bit 0 enable, bit 1 one-shot
          cfg.enable  <= cmd.data[0];
          cfg.oneshot <= cmd.data[1];
        end
        tick_counter_pkg::OP_SET_TICK: begin
          // Low byte only
          cfg.tick_value <= cmd.data[`TC_TICK_W-1:0];
        end
        tick_counter_pkg::OP_SET_LOAD: begin
          cfg.load_value <= cmd.data[`TC_CNT_W-1:0];
        end
        tick_counter_pkg::OP_SET_WATERMARK: begin
          cfg.watermark <= cmd.data[`TC_CNT_W-1:0];
        end
        tick_counter_pkg::OP_SET_LED: begin
          led_value <= cmd.data[`TC_LED_W-1:0];
        end
        default: begin
          // NOP and pulse opcodes leave the fields alone
        end
      endcase
    end
  end

  //----------------------------------------
  // Load and clear pulses
  //----------------------------------------

  // High for one cycle per command
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      pulse <= '0;
    end else begin
      pulse.load  <= cmd.strobe && (cmd.op == tick_counter_pkg::OP_LOAD);
      pulse.clear <= cmd.strobe && (cmd.op == tick_counter_pkg::OP_CLEAR);
    end
  end

endmodule

`default_nettype wire

/* rtl/event_counter.sv */
// Event counter with watermark

`timescale 1ns/1ps
`default_nettype none

`include "tick_counter_defines.svh"

module event_counter (
  input  logic                          clk_main_a0,
  input  logic                          rst_main_n_sync,
  input  tick_counter_pkg::cnt_cfg_t    cfg,
  input  tick_counter_pkg::cnt_pulse_t  pulse,
  input  logic                          tick,
  input  logic [`TC_TICK_W-1:0]         tick_cnt,
  output tick_counter_pkg::cnt_status_t status
);

  logic [`TC_CNT_W-1:0] cnt;
  logic                 cnt_at_max;
  logic                 ge_watermark;

  //----------------------------------------
  // Count register
  //----------------------------------------

  // All ones, the one-shot ceiling
  assign cnt_at_max = &cnt;

  // Priority clear, load, hold, tick
  // Tick already carries enable
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      cnt <= '0;
    end else if (pulse.clear) begin
      cnt <= '0;
    end else if (pulse.load) begin
      // Taken even while disabled
      cnt <= cfg.load_value;
    end else if (!cfg.enable) begin
      cnt <= cnt;
    end else if (tick) begin
      // One-shot saturates, otherwise natural wrap to zero
      if (cfg.oneshot && cnt_at_max) begin
        cnt <= cnt;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  //----------------------------------------
  // Watermark and status
  //----------------------------------------

  // Inclusive compare
  assign ge_watermark = (cnt >= cfg.watermark);

  assign status.tick         = tick;
  assign status.ge_watermark = ge_watermark;
  assign status.tick_cnt     = tick_cnt;
  assign status.cnt          = cnt;

endmodule

`default_nettype wire

/* rtl/tick_counter_pkg.sv */
// Tick counter types

`default_nettype none

`include "tick_counter_defines.svh"

package tick_counter_pkg;

  // Command opcodes
  typedef enum logic [2:0] {
    OP_NOP           = 3'd0,
    OP_SET_CTRL      = 3'd1,
    OP_SET_TICK      = 3'd2,
    OP_SET_LOAD      = 3'd3,
    OP_SET_WATERMARK = 3'd4,
    OP_SET_LED       = 3'd5,
    OP_LOAD          = 3'd6,
    OP_CLEAR         = 3'd7
  } cmd_op_e;

  // Single-cycle command strobe, no back-pressure
  typedef struct packed {
    logic                  strobe;
    cmd_op_e               op;
    logic [`TC_DATA_W-1:0] data;
  } cmd_t;

  // Counter configuration
  typedef struct packed {
    logic                 enable;
    logic                 oneshot;
    logic [`TC_TICK_W-1:0] tick_value;
    logic [`TC_CNT_W-1:0]  load_value;
    logic [`TC_CNT_W-1:0]  watermark;
  } cnt_cfg_t;

  // One-cycle control pulses
  typedef struct packed {
    logic load;
    logic clear;
  } cnt_pulse_t;

  // Observed counter state
  typedef struct packed {
    logic                  tick;
    logic                  ge_watermark;
    logic [`TC_TICK_W-1:0] tick_cnt;
    logic [`TC_CNT_W-1:0]  cnt;
  } cnt_status_t;

endpackage

`default_nettype wire

/* rtl/tick_counter_top.sv */
// Tick counter top level

`timescale 1ns/1ps
`default_nettype none

`include "tick_counter_defines.svh"

module tick_counter_top (
  input  logic                          clk_main_a0,
  input  logic                          rst_main_n_sync,
  input  tick_counter_pkg::cmd_t        cmd,
  input  logic [`TC_LED_W-1:0]          vdip,
  output tick_counter_pkg::cnt_status_t status,
  output logic [`TC_LED_W-1:0]          vled
);

  tick_counter_pkg::cnt_cfg_t   cfg;
  tick_counter_pkg::cnt_pulse_t pulse;
  logic [`TC_LED_W-1:0]         led_value;
  logic                         tick;
  logic [`TC_TICK_W-1:0]        tick_cnt;

  // Command decode feeds both branches
  cnt_cfg_regs u_cnt_cfg_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .cmd             (cmd),
    .cfg             (cfg),
    .pulse           (pulse),
    .led_value       (led_value)
  );

  //----------------------------------------
  // Counter chain
  //----------------------------------------

  // Prescaler paces the counter
  tick_prescaler u_tick_prescaler (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .cfg             (cfg),
    .pulse           (pulse),
    .tick            (tick),
    .tick_cnt        (tick_cnt)
  );

  event_counter u_event_counter (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .cfg             (cfg),
    .pulse           (pulse),
    .tick            (tick),
    .tick_cnt        (tick_cnt),
    .status          (status)
  );

  // LED branch, independent of the counter
  vled_status u_vled_status (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .led_value       (led_value),
    .vdip            (vdip),
    .vled            (vled)
  );

endmodule

`default_nettype wire

/* rtl/tick_prescaler.sv */
// Tick prescaler

`timescale 1ns/1ps
`default_nettype none

`include "tick_counter_defines.svh"

module tick_prescaler (
  input  logic                         clk_main_a0,
  input  logic                         rst_main_n_sync,
  input  tick_counter_pkg::cnt_cfg_t   cfg,
  input  tick_counter_pkg::cnt_pulse_t pulse,
  output logic                         tick,
  output logic [`TC_TICK_W-1:0]        tick_cnt
);

  // Fires at or past the divider, so a lowered divider ticks at once
  assign tick = cfg.enable && (tick_cnt >= cfg.tick_value);

  // Clear first, then hold when disabled, else wrap or count
  // Load only touches the event count, so the prescaler runs through it
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      tick_cnt <= '0;
    end else if (pulse.clear) begin
      tick_cnt <= '0;
    end else if (!cfg.enable) begin
      tick_cnt <= tick_cnt;
    end else if (tick) begin
      tick_cnt <= '0;
    end else begin
      tick_cnt <= tick_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* rtl/vled_status.sv */
// Virtual LED status path

`timescale 1ns/1ps
`default_nettype none

`include "tick_counter_defines.svh"

module vled_status (
  input  logic                 clk_main_a0,
  input  logic                 rst_main_n_sync,
  input  logic [`TC_LED_W-1:0] led_value,
  input  logic [`TC_LED_W-1:0] vdip,
  output logic [`TC_LED_W-1:0] vled
);

  logic [`TC_LED_W-1:0] vdip_q;
  logic [`TC_LED_W-1:0] vdip_q2;
  logic [`TC_LED_W-1:0] led_q;
  logic [`TC_LED_W-1:0] led_shadow_q;

  //----------------------------------------
  // DIP synchronizer and output flop
  //----------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vdip_q  <= '0;
      vdip_q2 <= '0;
      vled    <= '0;
    end else begin
      // Two stages for the async DIP inputs
      vdip_q  <= vdip;
      vdip_q2 <= vdip_q;
      // LEDs masked by the synchronized switches
      vled    <= led_shadow_q & vdip_q2;
    end
  end

  // LED register, then its shadow
  always_ff @(posedge clk_main_a0) begin
    led_q        <= led_value;
    led_shadow_q <= led_q;
  end

endmodule

`default_nettype wire

/* testbench/tb_tick_counter.sv */
// Tick counter testbench

`timescale 1ns/1ps
`default_nettype none

`include "tick_counter_defines.svh"

module tb_tick_counter;

  localparam int CLK_PERIOD      = 40;
  localparam int RESET_CYCLES    = 8;
  localparam int DIRECTED_CYCLES = 220;
  localparam int RANDOM_CYCLES   = 2000;
  localparam int CYCLE_LIMIT     = 2 * DIRECTED_CYCLES + RANDOM_CYCLES;

  logic                          clk_main_a0;
  logic                          rst_main_n_sync;
  tick_counter_pkg::cmd_t        cmd;
  logic [`TC_LED_W-1:0]          vdip;
  tick_counter_pkg::cnt_status_t status;
  logic [`TC_LED_W-1:0]          vled;

  // Cycle model state
  logic                  m_en;
  logic                  m_oneshot;
  logic [`TC_TICK_W-1:0] m_tick_value;
  logic [`TC_CNT_W-1:0]  m_load_value;
  logic [`TC_CNT_W-1:0]  m_watermark;
  logic [`TC_LED_W-1:0]  m_led_value;
  logic                  m_load;
  logic                  m_clear;
  logic [`TC_TICK_W-1:0] m_tick_cnt;
  logic [`TC_CNT_W-1:0]  m_cnt;
  logic [`TC_LED_W-1:0]  m_led_reg;
  logic [`TC_LED_W-1:0]  m_led_shadow;
  logic [`TC_LED_W-1:0]  m_dip_sync1;
  logic [`TC_LED_W-1:0]  m_dip_sync2;
  logic [`TC_LED_W-1:0]  m_vled;

  int unsigned cycle_count = 0;
  int unsigned fail_count  = 0;
  logic [31:0] rng_state;

  tick_counter_top u_dut (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .cmd             (cmd),
    .vdip            (vdip),
    .status          (status),
    .vled            (vled)
  );

  initial begin
    clk_main_a0 = 1'b0;
    forever #(CLK_PERIOD / 2) clk_main_a0 = ~clk_main_a0;
  end

  // Run limit, directed part twice over plus random part
  always @(posedge clk_main_a0) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("ERRORS FOUND");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  //----------------------------------------
  // Helpers
  //----------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_field(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      fail_count++;
      $display("Fail at time %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1, "Value mismatch on %s", name);
    end
  endtask

  task automatic reset_model();
    m_en         = 1'b0;
    m_oneshot    = 1'b0;
    m_tick_value = '0;
    m_load_value = '0;
    m_watermark  = '0;
    m_led_value  = '0;
    m_load       = 1'b0;
    m_clear      = 1'b0;
    m_tick_cnt   = '0;
    m_cnt        = '0;
    m_led_reg    = '0;
    m_led_shadow = '0;
    m_dip_sync1  = '0;
    m_dip_sync2  = '0;
    m_vled       = '0;
  endtask

  // One clock edge of the model, older state read before it is overwritten
  task automatic step_model();
    logic tick_m;
    tick_m = m_en && (m_tick_cnt >= m_tick_value);
    // LED pipeline, output stage first
    m_vled       = m_led_shadow & m_dip_sync2;
    m_led_shadow = m_led_reg;
    m_led_reg    = m_led_value;
    m_dip_sync2  = m_dip_sync1;
    m_dip_sync1  = vdip;
    // Clear, load, hold, tick
    if (m_clear) begin
      m_tick_cnt = '0;
      m_cnt      = '0;
    end else begin
      if (m_load) begin
        m_cnt = m_load_value;
      end else if (tick_m && !(m_oneshot && m_cnt == '1)) begin
        m_cnt = m_cnt + 1'b1;
      end
      // Prescaler ignores load
      if (m_en) begin
        m_tick_cnt = tick_m ? '0 : m_tick_cnt + 1'b1;
      end
    end
    // Pulses and registers from this edge's command
    m_load  = cmd.strobe && (cmd.op == tick_counter_pkg::OP_LOAD);
    m_clear = cmd.strobe && (cmd.op == tick_counter_pkg::OP_CLEAR);
    if (cmd.strobe) begin
      case (cmd.op)
        tick_counter_pkg::OP_SET_CTRL: begin
          m_en      = cmd.data[0];
          m_oneshot = cmd.data[1];
        end
        tick_counter_pkg::OP_SET_TICK:      m_tick_value = cmd.data[`TC_TICK_W-1:0];
        tick_counter_pkg::OP_SET_LOAD:      m_load_value = cmd.data;
        tick_counter_pkg::OP_SET_WATERMARK: m_watermark  = cmd.data;
        tick_counter_pkg::OP_SET_LED:       m_led_value  = cmd.data;
        default: begin
        end
      endcase
    end
  endtask

  task automatic check_outputs();
    check_field("status.tick", m_en && (m_tick_cnt >= m_tick_value), status.tick);
    check_field("status.ge_watermark", m_cnt >= m_watermark, status.ge_watermark);
    check_field("status.tick_cnt", m_tick_cnt, status.tick_cnt);
    check_field("status.cnt", m_cnt, status.cnt);
    check_field("vled", m_vled, vled);
    assert (u_dut.u_props.fail_count == 0) else begin
      fail_count++;
      $display("A bound property assertion on the DUT failed at time %0t", $time);
      $display("ERRORS FOUND");
      $fatal(1, "Property failure");
    end
  endtask

  // Inputs change 2 ns after the edge, outputs checked 1 ns after it
  task automatic apply_cycle(input logic strobe, input tick_counter_pkg::cmd_op_e op,
                             input logic [`TC_DATA_W-1:0] data,
                             input logic [`TC_LED_W-1:0] dip);
    cmd.strobe = strobe;
    cmd.op     = op;
    cmd.data   = data;
    vdip       = dip;
    @(posedge clk_main_a0);
    step_model();
    #1;
    check_outputs();
    #1;
  endtask

  task automatic send_cmd(input tick_counter_pkg::cmd_op_e op,
                          input logic [`TC_DATA_W-1:0] data);
    apply_cycle(1'b1, op, data, vdip);
  endtask

  task automatic wait_idle(input int n);
    repeat (n) apply_cycle(1'b0, tick_counter_pkg::OP_NOP, '0, vdip);
  endtask

  //----------------------------------------
  // Test sequence
  //----------------------------------------
  initial begin
    logic [31:0]           r;
    logic [`TC_CNT_W-1:0]  w;
    logic [`TC_DATA_W-1:0] data;
    logic [`TC_LED_W-1:0]  dip;
    logic                  strobe;
    tick_counter_pkg::cmd_op_e op;

    rng_state       = 32'hf8cb_b511;
    rst_main_n_sync = 1'b0;
    cmd             = '0;
    vdip            = '0;
    reset_model();
    repeat (RESET_CYCLES) @(posedge clk_main_a0);
    #2;
    rst_main_n_sync = 1'b1;

    // Quiet after reset, DIPs up but no LED value
    vdip = 16'hffff;
    wait_idle(10);

    // Count rate for a few dividers
    for (int t = 0; t < 9; t += 3) begin
      send_cmd(tick_counter_pkg::OP_SET_TICK, t);
      send_cmd(tick_counter_pkg::OP_SET_CTRL, 16'h0001);
      send_cmd(tick_counter_pkg::OP_CLEAR, '0);
      wait_idle(1);
      wait_idle(4 * (t + 1));
      check_field("status.cnt", 4, status.cnt);
    end

    // Load while disabled, hold, clear
    send_cmd(tick_counter_pkg::OP_SET_CTRL, 16'h0000);
    send_cmd(tick_counter_pkg::OP_SET_LOAD, 16'h1234);
    send_cmd(tick_counter_pkg::OP_LOAD, '0);
    wait_idle(1);
    check_field("status.cnt", 16'h1234, status.cnt);
    wait_idle(4);
    check_field("status.cnt", 16'h1234, status.cnt);
    send_cmd(tick_counter_pkg::OP_CLEAR, '0);
    wait_idle(1);
    check_field("status.tick_cnt", 0, status.tick_cnt);
    // Load and clear each beat a tick every cycle
    send_cmd(tick_counter_pkg::OP_SET_TICK, 16'h0000);
    send_cmd(tick_counter_pkg::OP_SET_CTRL, 16'h0001);
    wait_idle(3);
    send_cmd(tick_counter_pkg::OP_LOAD, '0);
    wait_idle(1);
    check_field("status.cnt", 16'h1234, status.cnt);
    send_cmd(tick_counter_pkg::OP_CLEAR, '0);
    wait_idle(1);
    check_field("status.cnt", 0, status.cnt);

    // Wrap, then saturate in one-shot
    send_cmd(tick_counter_pkg::OP_SET_LOAD, 16'hffff);
    send_cmd(tick_counter_pkg::OP_SET_TICK, 16'h0002);
    send_cmd(tick_counter_pkg::OP_SET_CTRL, 16'h0001);
    send_cmd(tick_counter_pkg::OP_LOAD, '0);
    wait_idle(1);
    wait_idle(3);
    check_field("status.cnt", 0, status.cnt);
    send_cmd(tick_counter_pkg::OP_SET_CTRL, 16'h0003);
    send_cmd(tick_counter_pkg::OP_LOAD, '0);
    wait_idle(10);
    check_field("status.cnt", 16'hffff, status.cnt);

    // Watermark just below, at and above
    send_cmd(tick_counter_pkg::OP_SET_CTRL, 16'h0000);
    repeat (8) begin
      rng_state = xorshift32(rng_state);
      w = rng_state[15:0];
      send_cmd(tick_counter_pkg::OP_SET_WATERMARK, w);
      for (int d = -1; d <= 1; d++) begin
        send_cmd(tick_counter_pkg::OP_SET_LOAD, w + d);
        send_cmd(tick_counter_pkg::OP_LOAD, '0);
        wait_idle(1);
        if (d == 0) begin
          check_field("status.ge_watermark", 1, status.ge_watermark);
        end
      end
    end

    // LED masking and its latencies
    send_cmd(tick_counter_pkg::OP_SET_LED, 16'ha5c3);
    wait_idle(3);
    check_field("vled", 16'ha5c3, vled);
    vdip = 16'h0f0f;
    wait_idle(3);
    check_field("vled", 16'h0503, vled);

    // Random mix, roughly one strobe in three
    repeat (RANDOM_CYCLES) begin
      rng_state = xorshift32(rng_state);
      r         = rng_state;
      strobe    = (r % 3) == 0;
      op        = tick_counter_pkg::cmd_op_e'(r[4:2]);
      rng_state = xorshift32(rng_state);
      data      = rng_state[15:0];
      // Small dividers keep ticks frequent
      if (op == tick_counter_pkg::OP_SET_TICK) begin
        data = {13'd0, data[2:0]};
      end
      if (op == tick_counter_pkg::OP_SET_CTRL && r[5]) begin
        data[0] = 1'b1;
      end
      // Near the top now and then for saturation
      if (op == tick_counter_pkg::OP_SET_LOAD && r[8:6] == 3'd0) begin
        data = 16'hfffe;
      end
      dip = (r[11:9] == 3'd0) ? rng_state[31:16] : vdip;
      apply_cycle(strobe, op, data, dip);
    end

    if (fail_count == 0 && u_dut.u_props.fail_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/tick_counter_properties.sv */
// Tick counter bound assertions

`timescale 1ns/1ps
`default_nettype none

`include "tick_counter_defines.svh"

module tick_counter_properties (
  input logic                          clk_main_a0,
  input logic                          rst_main_n_sync,
  input tick_counter_pkg::cnt_cfg_t    cfg,
  input tick_counter_pkg::cnt_pulse_t  pulse,
  input tick_counter_pkg::cnt_status_t status,
  input logic [`TC_LED_W-1:0]          vdip,
  input logic [`TC_LED_W-1:0]          vled
);

  // Read by the testbench each cycle
  int unsigned fail_count = 0;

  // Clear zeroes both counts one edge later
  clear_zeroes_counts: assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    pulse.clear |=> (status.cnt == '0 && status.tick_cnt == '0))
  else begin
    fail_count++;
    $error("clear pulse did not zero both counts");
  end

  // Synchronized DIP is the input three samples back
  vled_within_dip: assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (vled & ~$past(vdip, 3)) == '0)
  else begin
    fail_count++;
    $error("vled has a bit set that the synchronized DIP value lacks");
  end

  // Disabled and no pulses, count frozen
  idle_cnt_stable: assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (!cfg.enable && !pulse.load && !pulse.clear) |=> $stable(status.cnt))
  else begin
    fail_count++;
    $error("cnt changed while disabled without a pulse");
  end

endmodule

bind tick_counter_top tick_counter_properties u_props (
  .clk_main_a0     (clk_main_a0),
  .rst_main_n_sync (rst_main_n_sync),
  .cfg             (cfg),
  .pulse           (pulse),
  .status          (status),
  .vdip            (vdip),
  .vled            (vled)
);

`default_nettype wire

/* tick_counter.f */
+incdir+include
rtl/tick_counter_pkg.sv
rtl/cnt_cfg_regs.sv
rtl/tick_prescaler.sv
rtl/event_counter.sv
rtl/vled_status.sv
rtl/tick_counter_top.sv
testbench/tick_counter_properties.sv
testbench/tb_tick_counter.sv
